/* design/video_pkg.sv */
`default_nettype none

package video_pkg;

    // ----------------------------------------------------------------------
    // Line geometry and pixel pacing
    // ----------------------------------------------------------------------

    // 28 pixels per chunk, two 40-column bytes doubled
    localparam int CHUNK_PIXELS  = 28;
    localparam int NUM_CHUNKS    = 20;
    localparam int LINE_PIXELS   = 560;
    localparam int VISIBLE_LINES = 192;
    // One pixel every 4 clocks
    localparam int PIX_GAP       = 4;

    // Memory port latencies in clocks
    localparam int VRAM_LATENCY  = 3;
    localparam int ROM_LATENCY   = 2;

    // Bus and data widths
    localparam int VRAM_AW       = 16;
    localparam int VRAM_DW       = 32;
    localparam int ROM_AW        = 10;
    localparam int COLOR_W       = 4;
    localparam int RGB_W         = 18;

    // Standard 16-color palette as RGB444, indexed by color nibble
    localparam logic [11:0] PALETTE [0:15] = '{
        12'h000, 12'h924, 12'h42a, 12'hd4e,
        12'h064, 12'h888, 12'h39e, 12'hcbf,
        12'h450, 12'hc73, 12'h888, 12'hfac,
        12'h3c2, 12'hcd6, 12'h7ec, 12'hfff
    };

    // ----------------------------------------------------------------------
    // Shared enums
    // ----------------------------------------------------------------------

    typedef enum logic [1:0] {
        LINE_TEXT40,
        LINE_LORES40,
        LINE_HIRES40
    } line_kind_e;

    // Chunk fetcher FSM steps
    typedef enum logic [2:0] {
        FE_IDLE,
        FE_READ,
        FE_WAIT,
        FE_GLYPH0,
        FE_GLYPH1,
        FE_FULL
    } fetch_state_e;

endpackage

`default_nettype wire

/* design/video_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// Per-scanline setup, sent once at the start of each visible line
interface line_if
    import video_pkg::*;
();
    logic               start;
    line_kind_e         kind;
    logic [VRAM_AW-1:0] line_base;
    logic [7:0]         row;
    logic               monochrome;
    logic [COLOR_W-1:0] text_color;
    logic [COLOR_W-1:0] bg_color;

    modport producer (
        output start, kind, line_base, row, monochrome, text_color, bg_color
    );
    modport consumer (
        input start, kind, line_base, row, monochrome, text_color, bg_color
    );
endinterface

// One expanded 28-pixel chunk, valid/take handshake
interface chunk_if
    import video_pkg::*;
();
    logic                    valid;
    logic                    take;
    logic [CHUNK_PIXELS-1:0] bits;
    // Lores nibble for the left half of the chunk
    logic [COLOR_W-1:0]      color;

    modport producer (output valid, bits, color, input take);
    modport consumer (input valid, bits, color, output take);
endinterface

`default_nettype wire

/* design/video_mode_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module video_mode_regs
    import video_pkg::*;
(
    input  logic               a2bus_if,
    input  logic               rst_i,
    input  logic               text_mode_i,
    input  logic               hires_mode_i,
    input  logic               mixed_mode_i,
    input  logic               page2_i,
    input  logic               monochrome_i,
    input  logic [COLOR_W-1:0] text_color_i,
    input  logic [COLOR_W-1:0] background_color_i,
    input  logic [8:0]         scanline_i,
    input  logic               hsync_i,
    input  logic               vsync_i,
    output logic               fb_vsync_o,
    line_if.producer           line_o
);

    // Frame-latched soft switches
    logic               text_r;
    logic               hires_r;
    logic               mixed_r;
    logic               page2_r;
    logic               mono_r;
    logic [COLOR_W-1:0] text_color_r;
    logic [COLOR_W-1:0] bg_color_r;

    logic [7:0]         row_w;
    logic               visible_w;
    logic               text_line_w;
    line_kind_e         kind_w;
    logic [VRAM_AW-1:0] row_offset_w;
    logic [VRAM_AW-1:0] base_w;

    assign row_w     = scanline_i[7:0];
    assign visible_w = scanline_i < 9'(VISIBLE_LINES);

    // Rows 160..191 have bits 7 and 5 set, the mixed-mode text window
    assign text_line_w = text_r | (mixed_r & row_w[7] & row_w[5]);

    always_comb begin
        if (text_line_w)
            kind_w = LINE_TEXT40;
        else if (hires_r)
            kind_w = LINE_HIRES40;
        else
            kind_w = LINE_LORES40;
    end

    // Interleaved row offset, 128 per row group plus 40 per third of screen
    assign row_offset_w = VRAM_AW'({row_w[5:3], 7'd0})
                        + VRAM_AW'({row_w[7:6], 5'd0})
                        + VRAM_AW'({row_w[7:6], 3'd0});

    always_comb begin
        if (kind_w == LINE_HIRES40)
            // Hires adds 1K per scanline within the text row
            base_w = (page2_r ? 16'h4000 : 16'h2000)
                   + VRAM_AW'({row_w[2:0], 10'd0}) + row_offset_w;
        else
            base_w = (page2_r ? 16'h0800 : 16'h0400) + row_offset_w;
    end

    // ----------------------------------------------------------------------
    // Mode latch, vsync echo and line start
    // ----------------------------------------------------------------------

    always_ff @(posedge a2bus_if) begin
        if (rst_i) begin
            text_r        <= 1'b1;
            hires_r       <= 1'b0;
            mixed_r       <= 1'b0;
            page2_r       <= 1'b0;
            mono_r        <= 1'b0;
            text_color_r  <= 4'hf;
            bg_color_r    <= 4'h0;
            fb_vsync_o    <= 1'b0;
            line_o.start  <= 1'b0;
        end else begin
            fb_vsync_o   <= vsync_i;
            line_o.start <= hsync_i & visible_w;
            if (vsync_i) begin
                text_r       <= text_mode_i;
                hires_r      <= hires_mode_i;
                mixed_r      <= mixed_mode_i;
                page2_r      <= page2_i;
                mono_r       <= monochrome_i;
                text_color_r <= text_color_i;
                bg_color_r   <= background_color_i;
            end
        end
    end

    // Line setup, held until the next visible hsync
    always_ff @(posedge a2bus_if) begin
        if (hsync_i && visible_w) begin
            line_o.kind       <= kind_w;
            line_o.line_base  <= base_w;
            line_o.row        <= row_w;
            line_o.monochrome <= mono_r;
            line_o.text_color <= text_color_r;
            line_o.bg_color   <= bg_color_r;
        end
    end

endmodule

`default_nettype wire

/* design/chunk_fetcher.sv */
`timescale 1ns/1ps
`default_nettype none

module chunk_fetcher
    import video_pkg::*;
(
    input  logic               a2bus_if,
    input  logic               rst_i,
    line_if.consumer           line_i,
    output logic [VRAM_AW-1:0] video_address_o,
    output logic               video_rd_o,
    input  logic [VRAM_DW-1:0] video_data_i,
    output logic [ROM_AW-1:0]  char_rom_addr_o,
    input  logic [7:0]         char_rom_data_i,
    chunk_if.producer          chunk_o
);

    fetch_state_e            state_r;
    logic [4:0]              chunk_r;
    // Shared latency counter for VRAM and glyph waits
    logic [1:0]              wait_r;
    logic [VRAM_DW-1:0]      data_r;
    logic [CHUNK_PIXELS-1:0] bits_r;
    logic [COLOR_W-1:0]      color_r;
    logic [7:0]              glyph_char_w;

    // Each 40-column pixel is shown twice
    function automatic logic [13:0] double7(input logic [6:0] b);
        logic [13:0] d;
        for (int i = 0; i < 7; i++) begin
            d[2*i]   = b[i];
            d[2*i+1] = b[i];
        end
        return d;
    endfunction

    // Lores block, low nibble on the upper half of the text row
    function automatic logic [3:0] lores_nibble(input logic [7:0] b, input logic lower);
        return lower ? b[7:4] : b[3:0];
    endfunction

    // ----------------------------------------------------------------------
    // Memory ports
    // ----------------------------------------------------------------------

    // Chunk c sits at word line_base + 2c
    assign video_rd_o      = (state_r == FE_READ);
    assign video_address_o = line_i.line_base + {{(VRAM_AW-6){1'b0}}, chunk_r, 1'b0};

    // Left character first, right character while its data is in flight
    assign glyph_char_w    = (state_r == FE_GLYPH0) ? data_r[7:0] : data_r[23:16];
    assign char_rom_addr_o = {glyph_char_w[7], glyph_char_w[5:0], line_i.row[2:0]};

    assign chunk_o.valid = (state_r == FE_FULL);
    assign chunk_o.bits  = bits_r;
    assign chunk_o.color = color_r;

    // ----------------------------------------------------------------------
    // Fetch FSM
    // ----------------------------------------------------------------------

    always_ff @(posedge a2bus_if) begin
        if (rst_i) begin
            state_r <= FE_IDLE;
            chunk_r <= 5'd0;
            wait_r  <= 2'd0;
        end else if (line_i.start) begin
            state_r <= FE_READ;
            chunk_r <= 5'd0;
        end else begin
            case (state_r)
                FE_IDLE: ;
                FE_READ: begin
                    wait_r  <= 2'(VRAM_LATENCY - 1);
                    state_r <= FE_WAIT;
                end
                FE_WAIT: begin
                    if (wait_r == 2'd0)
                        state_r <= (line_i.kind == LINE_TEXT40) ? FE_GLYPH0 : FE_FULL;
                    else
                        wait_r <= wait_r - 2'd1;
                end
                FE_GLYPH0: begin
                    wait_r  <= 2'(ROM_LATENCY);
                    state_r <= FE_GLYPH1;
                end
                FE_GLYPH1: begin
                    if (wait_r == 2'd0)
                        state_r <= FE_FULL;
                    else
                        wait_r <= wait_r - 2'd1;
                end
                FE_FULL: begin
                    // Stop after the last chunk of the line
                    if (chunk_o.take) begin
                        if (chunk_r == 5'(NUM_CHUNKS - 1)) begin
                            state_r <= FE_IDLE;
                        end else begin
                            chunk_r <= chunk_r + 5'd1;
                            state_r <= FE_READ;
                        end
                    end
                end
                default: state_r <= FE_IDLE;
            endcase
        end
    end

    // Chunk expansion
    always_ff @(posedge a2bus_if) begin
        if (state_r == FE_WAIT && wait_r == 2'd0) begin
            data_r  <= video_data_i;
            color_r <= '0;
            case (line_i.kind)
                LINE_HIRES40:
                    // Bit 7 of each byte is not displayed
                    bits_r <= {double7(video_data_i[22:16]), double7(video_data_i[6:0])};
                LINE_LORES40: begin
                    color_r <= lores_nibble(video_data_i[7:0], line_i.row[2]);
                    bits_r  <= {{(CHUNK_PIXELS-4){1'b0}},
                                lores_nibble(video_data_i[23:16], line_i.row[2])};
                end
                default: ;
            endcase
        end
        // Glyph bytes arrive one cycle apart
        if (state_r == FE_GLYPH1 && wait_r == 2'd1)
            bits_r[13:0] <= double7(char_rom_data_i[6:0]);
        if (state_r == FE_GLYPH1 && wait_r == 2'd0)
            bits_r[27:14] <= double7(char_rom_data_i[6:0]);
    end

endmodule

`default_nettype wire

/* design/pixel_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_serializer
    import video_pkg::*;
(
    input  logic             a2bus_if,
    input  logic             rst_i,
    line_if.consumer         line_i,
    chunk_if.consumer        chunk_i,
    output logic             fb_we_o,
    output logic [RGB_W-1:0] fb_data_o
);

    typedef enum logic {
        SER_IDLE,
        SER_ACTIVE
    } ser_state_e;

    ser_state_e              state_r;
    // Shifter holds pixels of the current chunk, first pixel in bit 0
    logic                    full_r;
    logic [CHUNK_PIXELS-1:0] shift_r;
    logic [4:0]              pos_r;
    logic [1:0]              gap_r;
    logic [9:0]              pix_cnt_r;
    // Lores nibbles for the two halves
    logic [COLOR_W-1:0]      color0_r;
    logic [COLOR_W-1:0]      color1_r;

    logic                    emit_w;
    logic [COLOR_W-1:0]      pix_color_w;
    logic [11:0]             pix_rgb_w;

    // Pixel slot once every PIX_GAP cycles, skipped while the shifter is empty
    assign emit_w = (state_r == SER_ACTIVE) && full_r && (gap_r == 2'd0);

    // Refill as soon as the last pixel has left
    assign chunk_i.take = (state_r == SER_ACTIVE) && !full_r && chunk_i.valid;

    // ----------------------------------------------------------------------
    // Color select and palette lookup
    // ----------------------------------------------------------------------

    always_comb begin
        if (line_i.monochrome || line_i.kind == LINE_HIRES40)
            pix_color_w = shift_r[0] ? 4'hf : 4'h0;
        else if (line_i.kind == LINE_LORES40)
            pix_color_w = (pos_r < 5'(CHUNK_PIXELS / 2)) ? color0_r : color1_r;
        else
            pix_color_w = shift_r[0] ? line_i.text_color : line_i.bg_color;
    end

    assign pix_rgb_w = PALETTE[pix_color_w];

    // ----------------------------------------------------------------------
    // Line control
    // ----------------------------------------------------------------------

    always_ff @(posedge a2bus_if) begin
        if (rst_i) begin
            state_r   <= SER_IDLE;
            full_r    <= 1'b0;
            pos_r     <= 5'd0;
            gap_r     <= 2'd0;
            pix_cnt_r <= 10'd0;
            fb_we_o   <= 1'b0;
        end else begin
            fb_we_o <= emit_w;
            if (line_i.start) begin
                state_r   <= SER_ACTIVE;
                full_r    <= 1'b0;
                gap_r     <= 2'd0;
                pix_cnt_r <= 10'd0;
            end else if (state_r == SER_ACTIVE) begin
                // Free-running gap keeps writes on a 4-cycle grid
                gap_r <= (gap_r == 2'(PIX_GAP - 1)) ? 2'd0 : gap_r + 2'd1;
                if (chunk_i.take) begin
                    full_r <= 1'b1;
                    pos_r  <= 5'd0;
                end
                if (emit_w) begin
                    pos_r     <= pos_r + 5'd1;
                    pix_cnt_r <= pix_cnt_r + 10'd1;
                    if (pos_r == 5'(CHUNK_PIXELS - 1))
                        full_r <= 1'b0;
                    // Line done after the last write
                    if (pix_cnt_r == 10'(LINE_PIXELS - 1)) begin
                        state_r <= SER_IDLE;
                        full_r  <= 1'b0;
                    end
                end
            end
        end
    end

    // Shifter and output data
    always_ff @(posedge a2bus_if) begin
        if (chunk_i.take) begin
            shift_r  <= chunk_i.bits;
            color0_r <= chunk_i.color;
            color1_r <= chunk_i.bits[3:0];
        end else if (emit_w) begin
            shift_r <= shift_r >> 1;
        end
        // RGB444 widened to RGB666, low two bits of each channel zero
        if (emit_w)
            fb_data_o <= {pix_rgb_w[11:8], 2'b00, pix_rgb_w[7:4], 2'b00,
                          pix_rgb_w[3:0], 2'b00};
    end

endmodule

`default_nettype wire

/* design/apple_video_fb.sv */
`timescale 1ns/1ps
`default_nettype none

module apple_video_fb
    import video_pkg::*;
(
    input  logic               a2bus_if,
    input  logic               rst_i,
    input  logic               text_mode_i,
    input  logic               hires_mode_i,
    input  logic               mixed_mode_i,
    input  logic               page2_i,
    input  logic               monochrome_i,
    input  logic [COLOR_W-1:0] text_color_i,
    input  logic [COLOR_W-1:0] background_color_i,
    input  logic [8:0]         scanline_i,
    input  logic               hsync_i,
    input  logic               vsync_i,
    output logic [VRAM_AW-1:0] video_address_o,
    output logic               video_rd_o,
    input  logic [VRAM_DW-1:0] video_data_i,
    output logic [ROM_AW-1:0]  char_rom_addr_o,
    input  logic [7:0]         char_rom_data_i,
    output logic               fb_we_o,
    output logic [RGB_W-1:0]   fb_data_o,
    output logic               fb_vsync_o
);

    // Line setup from the mode latch, chunks from fetcher to serializer
    line_if  line_bus ();
    chunk_if chunk_bus ();

    video_mode_regs video_mode_regs_inst (
        .a2bus_if           (a2bus_if),
        .rst_i              (rst_i),
        .text_mode_i        (text_mode_i),
        .hires_mode_i       (hires_mode_i),
        .mixed_mode_i       (mixed_mode_i),
        .page2_i            (page2_i),
        .monochrome_i       (monochrome_i),
        .text_color_i       (text_color_i),
        .background_color_i (background_color_i),
        .scanline_i         (scanline_i),
        .hsync_i            (hsync_i),
        .vsync_i            (vsync_i),
        .fb_vsync_o         (fb_vsync_o),
        .line_o             (line_bus.producer)
    );

    chunk_fetcher chunk_fetcher_inst (
        .a2bus_if        (a2bus_if),
        .rst_i           (rst_i),
        .line_i          (line_bus.consumer),
        .video_address_o (video_address_o),
        .video_rd_o      (video_rd_o),
        .video_data_i    (video_data_i),
        .char_rom_addr_o (char_rom_addr_o),
        .char_rom_data_i (char_rom_data_i),
        .chunk_o         (chunk_bus.producer)
    );

    pixel_serializer pixel_serializer_inst (
        .a2bus_if  (a2bus_if),
        .rst_i     (rst_i),
        .line_i    (line_bus.consumer),
        .chunk_i   (chunk_bus.consumer),
        .fb_we_o   (fb_we_o),
        .fb_data_o (fb_data_o)
    );

endmodule

`default_nettype wire

/* tb/video_fb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module video_fb_checker
    import video_pkg::*;
(
    input  logic                    a2bus_if,
    input  logic                    rst_i,
    input  logic                    hsync_i,
    input  logic                    vsync_i,
    input  logic [8:0]              scanline_i,
    input  logic                    fb_we_i,
    input  logic                    video_rd_i,
    input  logic                    fb_vsync_i,
    input  fetch_state_e            fetch_state_i,
    input  logic                    chunk_valid_i,
    input  logic                    chunk_take_i,
    input  logic [CHUNK_PIXELS-1:0] chunk_bits_i,
    input  logic [COLOR_W-1:0]      chunk_color_i
);

    // Set by the first visible hsync after reset
    logic line_seen;

    always_ff @(posedge a2bus_if) begin
        if (rst_i)
            line_seen <= 1'b0;
        else if (hsync_i && scanline_i < 9'(VISIBLE_LINES))
            line_seen <= 1'b1;
    end

    // ----------------------------------------------------------------------
    // Reset and idle behavior
    // ----------------------------------------------------------------------

    a_reset_quiet: assert property (@(posedge a2bus_if)
        rst_i |=> (!fb_we_i && !video_rd_i && !fb_vsync_i))
        else $error("outputs active right after reset");

    // No fetch and no writes before any line was started
    a_idle_quiet: assert property (@(posedge a2bus_if) disable iff (rst_i)
        !line_seen |-> (!fb_we_i && !video_rd_i))
        else $error("activity with no visible hsync");

    // ----------------------------------------------------------------------
    // Top-level protocol
    // ----------------------------------------------------------------------

    // Frame pulse is vsync delayed by one clock
    a_vsync_high: assert property (@(posedge a2bus_if) disable iff (rst_i)
        vsync_i |=> fb_vsync_i)
        else $error("fb_vsync_o missing after vsync_i");
    a_vsync_low: assert property (@(posedge a2bus_if) disable iff (rst_i)
        !vsync_i |=> !fb_vsync_i)
        else $error("fb_vsync_o without vsync_i");

    // Writes on a grid of at least 4 clocks
    a_we_gap: assert property (@(posedge a2bus_if) disable iff (rst_i)
        fb_we_i |=> !fb_we_i ##1 !fb_we_i ##1 !fb_we_i)
        else $error("fb_we_o pulses closer than 4 cycles");

    // Read strobe is a single cycle
    a_rd_pulse: assert property (@(posedge a2bus_if) disable iff (rst_i)
        video_rd_i |=> !video_rd_i)
        else $error("video_rd_o longer than one cycle");

    // A full chunk stays in FE_FULL until take
    a_full_hold: assert property (@(posedge a2bus_if) disable iff (rst_i)
        (fetch_state_i == FE_FULL && !chunk_take_i) |=> fetch_state_i == FE_FULL)
        else $error("fetcher left FE_FULL without take");

    // Chunk data held steady while it waits for take
    a_data_hold: assert property (@(posedge a2bus_if) disable iff (rst_i)
        (chunk_valid_i && !chunk_take_i) |=>
            ($stable(chunk_bits_i) && $stable(chunk_color_i)))
        else $error("chunk data changed before take");

endmodule

bind apple_video_fb video_fb_checker video_fb_checker_inst (
    .a2bus_if      (a2bus_if),
    .rst_i         (rst_i),
    .hsync_i       (hsync_i),
    .vsync_i       (vsync_i),
    .scanline_i    (scanline_i),
    .fb_we_i       (fb_we_o),
    .video_rd_i    (video_rd_o),
    .fb_vsync_i    (fb_vsync_o),
    .fetch_state_i (chunk_fetcher_inst.state_r),
    .chunk_valid_i (chunk_bus.valid),
    .chunk_take_i  (chunk_bus.take),
    .chunk_bits_i  (chunk_bus.bits),
    .chunk_color_i (chunk_bus.color)
);

`default_nettype wire

/* tb/tb_apple_video_fb.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_apple_video_fb
    import video_pkg::*;
();

    // Clocks from one hsync to the next
    localparam int LINE_CYCLES = 2600;

    // Standard palette, RGB444
    localparam logic [11:0] REF_PALETTE [0:15] = '{
        12'h000, 12'h924, 12'h42a, 12'hd4e,
        12'h064, 12'h888, 12'h39e, 12'hcbf,
        12'h450, 12'hc73, 12'h888, 12'hfac,
        12'h3c2, 12'hcd6, 12'h7ec, 12'hfff
    };

    logic               a2bus_if;
    logic               rst_i;
    logic               text_mode_i;
    logic               hires_mode_i;
    logic               mixed_mode_i;
    logic               page2_i;
    logic               monochrome_i;
    logic [3:0]         text_color_i;
    logic [3:0]         background_color_i;
    logic [8:0]         scanline_i;
    logic               hsync_i;
    logic               vsync_i;
    logic [15:0]        video_address_o;
    logic               video_rd_o;
    logic [31:0]        video_data_i;
    logic [9:0]         char_rom_addr_o;
    logic [7:0]         char_rom_data_i;
    logic               fb_we_o;
    logic [RGB_W-1:0]   fb_data_o;
    logic               fb_vsync_o;

    // Memory images and their latency pipes
    logic [31:0]        vram [0:16383];
    logic [7:0]         char_rom [0:1023];
    logic [31:0]        vram_pipe [0:2];
    logic [2:0]         vram_vld;
    logic [7:0]         rom_pipe0;
    logic [7:0]         rom_pipe1;
    integer             seed;

    // Modes as the DUT should hold them after the last vsync
    logic               lat_text;
    logic               lat_hires;
    logic               lat_mixed;
    logic               lat_page2;
    logic               lat_mono;
    logic [3:0]         lat_tc;
    logic [3:0]         lat_bg;

    // Expected colors of the current line
    logic [3:0]         exp_color [0:LINE_PIXELS-1];
    logic               bw_only;
    int                 wr_total;
    int                 line_start;

    apple_video_fb apple_video_fb_inst (
        .a2bus_if           (a2bus_if),
        .rst_i              (rst_i),
        .text_mode_i        (text_mode_i),
        .hires_mode_i       (hires_mode_i),
        .mixed_mode_i       (mixed_mode_i),
        .page2_i            (page2_i),
        .monochrome_i       (monochrome_i),
        .text_color_i       (text_color_i),
        .background_color_i (background_color_i),
        .scanline_i         (scanline_i),
        .hsync_i            (hsync_i),
        .vsync_i            (vsync_i),
        .video_address_o    (video_address_o),
        .video_rd_o         (video_rd_o),
        .video_data_i       (video_data_i),
        .char_rom_addr_o    (char_rom_addr_o),
        .char_rom_data_i    (char_rom_data_i),
        .fb_we_o            (fb_we_o),
        .fb_data_o          (fb_data_o),
        .fb_vsync_o         (fb_vsync_o)
    );

    // 4 ns clock
    always #2 a2bus_if = ~a2bus_if;

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    // Palette entry widened to RGB666
    function automatic logic [RGB_W-1:0] rgb_of(input logic [3:0] c);
        logic [11:0] p;
        p = REF_PALETTE[c];
        return {p[11:8], 2'b00, p[7:4], 2'b00, p[3:0], 2'b00};
    endfunction

    // ----------------------------------------------------------------------
    // Memory models, answers driven on the falling edge
    // ----------------------------------------------------------------------

    // VRAM, data in the third cycle after the strobe, held until the next read
    always @(negedge a2bus_if) begin
        if (vram_vld[2])
            video_data_i <= vram_pipe[2];
        vram_vld     <= {vram_vld[1:0], video_rd_o};
        vram_pipe[2] <= vram_pipe[1];
        vram_pipe[1] <= vram_pipe[0];
        vram_pipe[0] <= vram[video_address_o[13:0]];
    end

    // Glyph ROM, two cycles from address to data
    always @(negedge a2bus_if) begin
        char_rom_data_i <= rom_pipe1;
        rom_pipe1       <= rom_pipe0;
        rom_pipe0       <= char_rom[char_rom_addr_o];
    end

    // ----------------------------------------------------------------------
    // Line prediction
    // ----------------------------------------------------------------------

    task automatic predict_line(input logic [7:0] row);
        line_kind_e  kind;
        logic [15:0] base;
        logic [31:0] word;
        logic [7:0]  col_byte;
        logic [7:0]  glyph;
        int          chunk;
        int          q;
        int          k;
        if (lat_text || (lat_mixed && row >= 8'd160))
            kind = LINE_TEXT40;
        else if (lat_hires)
            kind = LINE_HIRES40;
        else
            kind = LINE_LORES40;
        // Interleaved rows, 128 per group of 8 and 40 per third
        base = 16'(128 * ((row / 8) % 8) + 40 * (row / 64));
        if (kind == LINE_HIRES40)
            base = base + (lat_page2 ? 16'h4000 : 16'h2000) + 16'(1024 * (row % 8));
        else
            base = base + (lat_page2 ? 16'h0800 : 16'h0400);
        // Monochrome lores is only held to black or white
        bw_only = lat_mono && kind == LINE_LORES40;
        for (int p = 0; p < LINE_PIXELS; p++) begin
            chunk = p / CHUNK_PIXELS;
            q = p % CHUNK_PIXELS;
            word = vram[14'(base + 16'(2 * chunk))];
            col_byte = (q < 14) ? word[7:0] : word[23:16];
            // Each byte bit shows as two pixels
            k = (q % 14) / 2;
            case (kind)
                LINE_TEXT40: begin
                    glyph = char_rom[{col_byte[7], col_byte[5:0], row[2:0]}];
                    if (glyph[k])
                        exp_color[p] = lat_mono ? 4'hf : lat_tc;
                    else
                        exp_color[p] = lat_mono ? 4'h0 : lat_bg;
                end
                LINE_HIRES40:
                    exp_color[p] = col_byte[k] ? 4'hf : 4'h0;
                default:
                    exp_color[p] = row[2] ? col_byte[7:4] : col_byte[3:0];
            endcase
        end
    endtask

    // Pixel compare at each write, sampled mid-cycle
    always @(negedge a2bus_if) begin
        if (!rst_i && fb_we_o) begin
            if (wr_total - line_start < LINE_PIXELS) begin
                if (bw_only) begin
                    assert (fb_data_o == rgb_of(4'h0) || fb_data_o == rgb_of(4'hf))
                        else stop_on_failure($sformatf(
                            "CHECK FAILED at %0t ns: fb_data_o got %05h expected %05h or %05h",
                            $time, fb_data_o, rgb_of(4'h0), rgb_of(4'hf)));
                end else begin
                    assert (fb_data_o == rgb_of(exp_color[wr_total - line_start]))
                        else stop_on_failure($sformatf(
                            "CHECK FAILED at %0t ns: fb_data_o got %05h expected %05h",
                            $time, fb_data_o, rgb_of(exp_color[wr_total - line_start])));
                end
            end
            wr_total = wr_total + 1;
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus tasks
    // ----------------------------------------------------------------------

    task automatic set_switches(input logic t, h, m, p2, mono, input logic [3:0] tc, bg);
        @(negedge a2bus_if);
        text_mode_i        = t;
        hires_mode_i       = h;
        mixed_mode_i       = m;
        page2_i            = p2;
        monochrome_i       = mono;
        text_color_i       = tc;
        background_color_i = bg;
    endtask

    // Switches plus one vsync, and the model follows
    task automatic latch_modes(input logic t, h, m, p2, mono, input logic [3:0] tc, bg);
        set_switches(t, h, m, p2, mono, tc, bg);
        vsync_i = 1'b1;
        @(negedge a2bus_if);
        vsync_i   = 1'b0;
        lat_text  = t;
        lat_hires = h;
        lat_mixed = m;
        lat_page2 = p2;
        lat_mono  = mono;
        lat_tc    = tc;
        lat_bg    = bg;
    endtask

    task automatic run_line(input logic [8:0] scanline);
        int cycles;
        int expected;
        expected = (scanline < 9'(VISIBLE_LINES)) ? LINE_PIXELS : 0;
        @(negedge a2bus_if);
        if (expected != 0)
            predict_line(scanline[7:0]);
        line_start = wr_total;
        scanline_i = scanline;
        hsync_i    = 1'b1;
        @(negedge a2bus_if);
        hsync_i = 1'b0;
        cycles  = 1;
        while (wr_total - line_start < expected && cycles < LINE_CYCLES) begin
            @(negedge a2bus_if);
            cycles++;
        end
        if (wr_total - line_start < expected)
            stop_on_failure("Timed out waiting for the framebuffer writes of a line");
        // Rest of the line period, no further writes allowed
        while (cycles < LINE_CYCLES) begin
            @(negedge a2bus_if);
            cycles++;
        end
        assert (wr_total - line_start == expected)
            else stop_on_failure($sformatf(
                "CHECK FAILED at %0t ns: fb_we_o count got %0d expected %0d",
                $time, wr_total - line_start, expected));
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------

    initial begin
        logic [31:0] rnd;
        a2bus_if           = 1'b0;
        rst_i              = 1'b1;
        text_mode_i        = 1'b1;
        hires_mode_i       = 1'b0;
        mixed_mode_i       = 1'b0;
        page2_i            = 1'b0;
        monochrome_i       = 1'b0;
        text_color_i       = 4'hf;
        background_color_i = 4'h0;
        scanline_i         = 9'd0;
        hsync_i            = 1'b0;
        vsync_i            = 1'b0;
        video_data_i       = 32'd0;
        char_rom_data_i    = 8'd0;
        vram_vld           = 3'b000;
        wr_total           = 0;
        line_start         = 0;
        bw_only            = 1'b0;
        // Reset values of the mode latch
        lat_text  = 1'b1;
        lat_hires = 1'b0;
        lat_mixed = 1'b0;
        lat_page2 = 1'b0;
        lat_mono  = 1'b0;
        lat_tc    = 4'hf;
        lat_bg    = 4'h0;
        seed = 32'h3a409bb2;
        for (int i = 0; i < 16384; i++) begin
            rnd = $random(seed);
            vram[i] = rnd;
        end
        for (int i = 0; i < 1024; i++) begin
            rnd = $random(seed);
            char_rom[i] = rnd[7:0];
        end
        repeat (4) @(negedge a2bus_if);
        rst_i = 1'b0;
        // Quiet period with no hsync
        repeat (20) @(negedge a2bus_if);

        // TEXT40 page 1, colors 6 on 2
        latch_modes(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 4'd6, 4'd2);
        run_line(9'd0);
        run_line(9'd7);
        run_line(9'd100);

        // LORES40 page 2, both nibble halves
        latch_modes(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 4'd6, 4'd2);
        run_line(9'd3);
        run_line(9'd4);

        // HIRES40 mixed, graphics row then text window row
        latch_modes(1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 4'd6, 4'd2);
        run_line(9'd50);
        run_line(9'd170);

        // Monochrome lores, then a scanline below the visible area
        latch_modes(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 4'd6, 4'd2);
        run_line(9'd20);
        run_line(9'd200);

        // Switches move without vsync, line keeps the latched kind
        set_switches(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 4'd9, 4'd3);
        run_line(9'd21);
        latch_modes(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 4'd9, 4'd3);
        run_line(9'd21);

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
design/video_pkg.sv
design/video_ifs.sv
design/video_mode_regs.sv
design/chunk_fetcher.sv
design/pixel_serializer.sv
design/apple_video_fb.sv
tb/video_fb_checker.sv
tb/tb_apple_video_fb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_apple_video_fb \
    -f vlog.f \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^Everything OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
